// File: source/core_consts.svh
// ================================================
// Core constants
// Register count, data width and trap cause codes
// ================================================

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Integer register file size
`define CORE_NREGS 32

// Data path width
`define CORE_XLEN 32

// Synchronous exception codes
`define CORE_CAUSE_ILLEGAL 2
`define CORE_CAUSE_ECALL 11

// Machine external interrupt code
`define CORE_CAUSE_MEXT_IRQ 11

// Interrupt flag position in mcause
`define CORE_IRQ_BIT 31

`endif

// File: source/core_pkg.sv
// ================================================
// Core package
// Instruction kinds, debug state and debug causes
// ================================================

package core_pkg;

  // Modeled instruction kinds
  typedef enum logic [2:0] {
    OP_ADD     = 3'd0,
    OP_ADDI    = 3'd1,
    OP_ECALL   = 3'd2,
    OP_ILLEGAL = 3'd3,
    OP_EBREAK  = 3'd4,
    OP_DRET    = 3'd5
  } opcode_e;

  // Controller state, running or halted in debug
  typedef enum logic [0:0] {
    ST_RUN   = 1'b0,
    ST_DEBUG = 1'b1
  } dbg_state_e;

  // Values of dcsr.cause
  // Codes follow the debug spec numbering
  typedef enum logic [2:0] {
    DBG_NONE    = 3'd0,
    DBG_EBREAK  = 3'd1,
    DBG_HALTREQ = 3'd3
  } dbg_cause_e;

endpackage

// File: source/rvfi_pkg.sv
// ================================================
// RVFI package
// Trap and interrupt fields of a retirement record
// ================================================

package rvfi_pkg;

  // Trap information of one retired instruction
  typedef struct packed {
    // Synchronous exception taken
    logic       exception;
    // Exception code, zero when no exception
    logic [5:0] exception_cause;
    // Debug mode entered
    logic       debug;
    // Reason of the debug entry
    logic [2:0] debug_cause;
  } rvfi_trap_t;

  // Interrupt information of one retired instruction
  typedef struct packed {
    // First instruction of an interrupt handler
    logic        interrupt;
    // Interrupt code without the flag bit
    logic [10:0] cause;
  } rvfi_intr_t;

endpackage

// File: source/rvfi_if.sv
// ================================================
// RVFI bus
// One retirement record, from retire stage to
// the checker and the trace output
// ================================================

`include "core_consts.svh"

interface rvfi_if;

  logic                  valid;
  logic [4:0]            rs1_addr;
  logic [4:0]            rs2_addr;
  logic [`CORE_XLEN-1:0] rs1_rdata;
  logic [`CORE_XLEN-1:0] rs2_rdata;
  // Debug entry cause, zero when no entry
  logic [2:0]            dbg;
  // Debug mode before the instruction
  logic                  dbg_mode;
  rvfi_pkg::rvfi_trap_t  trap;
  rvfi_pkg::rvfi_intr_t  intr;
  logic [`CORE_XLEN-1:0] csr_dcsr_rdata;
  logic [`CORE_XLEN-1:0] csr_mcause_wdata;
  logic [`CORE_XLEN-1:0] csr_mcause_wmask;

  // Retire stage side
  modport source (
    output valid, rs1_addr, rs2_addr, rs1_rdata, rs2_rdata, dbg, dbg_mode,
    output trap, intr, csr_dcsr_rdata, csr_mcause_wdata, csr_mcause_wmask
  );

  // Observers, passive
  modport monitor (
    input valid, rs1_addr, rs2_addr, rs1_rdata, rs2_rdata, dbg, dbg_mode,
    input trap, intr, csr_dcsr_rdata, csr_mcause_wdata, csr_mcause_wmask
  );

endinterface

// File: source/reg_file.sv
// ================================================
// Integer register file
// Two combinational reads, one clocked write,
// all entries reset to zero
// ================================================

`include "core_consts.svh"

module reg_file (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [4:0]            rs1_addr,
  input  logic [4:0]            rs2_addr,
  output logic [`CORE_XLEN-1:0] rs1_rdata,
  output logic [`CORE_XLEN-1:0] rs2_rdata,
  input  logic                  we,
  input  logic [4:0]            waddr,
  input  logic [`CORE_XLEN-1:0] wdata
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

  // Architectural reset value is zero for every entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is hardwired to zero
  assign rs1_rdata = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_rdata = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

  // Retire stage filters rd == x0 before asserting the write
  a_no_x0_write: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    we |-> (waddr != 5'd0)
  ) else $fatal(1, "ERR %0t reg_file: write directed at x0", $time);

endmodule

// File: source/trap_ctrl.sv
// ================================================
// Trap and debug controller
// Classifies each instruction, holds mcause, dcsr
// and the debug-mode state
// ================================================

`include "core_consts.svh"

module trap_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  accept,
  input  core_pkg::opcode_e     op,
  input  logic                  irq,
  input  logic                  dbg_req,
  output rvfi_pkg::rvfi_trap_t  trap,
  output rvfi_pkg::rvfi_intr_t  intr,
  output logic [2:0]            dbg,
  output logic                  dbg_mode,
  output logic                  suppress_wb,
  output logic [`CORE_XLEN-1:0] dcsr_rdata,
  output logic [`CORE_XLEN-1:0] mcause_wdata,
  output logic [`CORE_XLEN-1:0] mcause_wmask
);

  core_pkg::dbg_state_e  state_q;
  core_pkg::dbg_cause_e  dbg_cause;
  logic [`CORE_XLEN-1:0] dcsr_q;
  logic [`CORE_XLEN-1:0] dcsr_next;
  logic [`CORE_XLEN-1:0] mcause_q;
  logic [`CORE_XLEN-1:0] mcause_new;
  logic                  in_run;
  logic                  enter_dbg;
  logic                  exc;
  logic                  take_irq;
  logic [5:0]            exc_code;

  assign in_run = (state_q == core_pkg::ST_RUN);

  // Debug entry, halt request ahead of ebreak
  always_comb begin
    dbg_cause = core_pkg::DBG_NONE;
    if (in_run && dbg_req) begin
      dbg_cause = core_pkg::DBG_HALTREQ;
    end else if (in_run && (op == core_pkg::OP_EBREAK)) begin
      dbg_cause = core_pkg::DBG_EBREAK;
    end
  end

  assign enter_dbg = (dbg_cause != core_pkg::DBG_NONE);

  // Exceptions are also flagged inside debug mode
  assign exc = !enter_dbg &&
               ((op == core_pkg::OP_ECALL) || (op == core_pkg::OP_ILLEGAL));
  assign exc_code = (op == core_pkg::OP_ECALL) ? 6'(`CORE_CAUSE_ECALL)
                                                : 6'(`CORE_CAUSE_ILLEGAL);

  // Interrupt has the lowest priority and is dropped in debug
  assign take_irq = in_run && irq && !enter_dbg && !exc;

  // New mcause value and write mask
  always_comb begin
    mcause_new   = '0;
    mcause_wmask = '0;
    if (exc) begin
      mcause_new[5:0] = exc_code;
      // No mcause write from debug mode
      mcause_wmask    = in_run ? '1 : '0;
    end else if (take_irq) begin
      mcause_new[`CORE_IRQ_BIT] = 1'b1;
      mcause_new[10:0]          = 11'(`CORE_CAUSE_MEXT_IRQ);
      mcause_wmask              = '1;
    end
  end

  // Unmasked bits keep their old value
  assign mcause_wdata = (mcause_q & ~mcause_wmask) | (mcause_new & mcause_wmask);

  // dcsr as seen after this instruction
  always_comb begin
    dcsr_next = dcsr_q;
    if (enter_dbg) begin
      dcsr_next[8:6] = dbg_cause;
    end
  end

  assign dcsr_rdata = dcsr_next;

  assign trap = '{
    exception:       exc,
    exception_cause: exc ? exc_code : 6'd0,
    debug:           enter_dbg,
    debug_cause:     dbg_cause
  };

  // Interrupt marks the first handler instruction, which still executes
  assign intr = '{
    interrupt: take_irq,
    cause:     take_irq ? 11'(`CORE_CAUSE_MEXT_IRQ) : 11'd0
  };

  assign dbg         = dbg_cause;
  assign dbg_mode    = !in_run;
  assign suppress_wb = enter_dbg || exc;

  // CSR and state updates on the acceptance edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= core_pkg::ST_RUN;
      dcsr_q   <= '0;
      mcause_q <= '0;
    end else if (accept) begin
      dcsr_q   <= dcsr_next;
      mcause_q <= mcause_wdata;
      if (enter_dbg) begin
        state_q <= core_pkg::ST_DEBUG;
      end else if (!in_run && (op == core_pkg::OP_DRET)) begin
        state_q <= core_pkg::ST_RUN;
      end
    end
  end

  // A debug entry always leaves a cause in dcsr
  a_debug_has_cause: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_run ##1 !in_run |-> (dcsr_q[8:6] != 3'(core_pkg::DBG_NONE))
  ) else $fatal(1, "ERR %0t trap_ctrl: debug entered without cause", $time);

endmodule

// File: source/retire_unit.sv
// ================================================
// Retirement stage
// Executes accepted instructions, writes back and
// registers one RVFI record per instruction
// ================================================

`include "core_consts.svh"

module retire_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  instr_valid,
  output logic                  instr_ready,
  input  core_pkg::opcode_e     instr_op,
  input  logic [4:0]            instr_rs1,
  input  logic [4:0]            instr_rs2,
  input  logic [4:0]            instr_rd,
  input  logic [`CORE_XLEN-1:0] instr_imm,
  input  logic                  trace_ready,
  rvfi_if.source                rvfi,
  output logic [4:0]            rs1_addr,
  output logic [4:0]            rs2_addr,
  input  logic [`CORE_XLEN-1:0] rs1_rdata,
  input  logic [`CORE_XLEN-1:0] rs2_rdata,
  output logic                  we,
  output logic [4:0]            waddr,
  output logic [`CORE_XLEN-1:0] wdata,
  output logic                  accept,
  input  rvfi_pkg::rvfi_trap_t  trap,
  input  rvfi_pkg::rvfi_intr_t  intr,
  input  logic [2:0]            dbg,
  input  logic                  dbg_mode,
  input  logic                  suppress_wb,
  input  logic [`CORE_XLEN-1:0] dcsr_rdata,
  input  logic [`CORE_XLEN-1:0] mcause_wdata,
  input  logic [`CORE_XLEN-1:0] mcause_wmask
);

  logic valid_q;
  logic writes_rd;

  // Stall only while a record waits on the consumer
  assign instr_ready = !(valid_q && !trace_ready);
  assign accept      = instr_valid && instr_ready;

  assign rs1_addr = instr_rs1;
  assign rs2_addr = instr_rs2;

  // ALU, ADD uses rs2, ADDI the immediate
  assign wdata = rs1_rdata + ((instr_op == core_pkg::OP_ADD) ? rs2_rdata : instr_imm);

  assign writes_rd = (instr_op == core_pkg::OP_ADD) || (instr_op == core_pkg::OP_ADDI);
  assign we        = accept && writes_rd && !suppress_wb && (instr_rd != 5'd0);
  assign waddr     = instr_rd;

  // Record valid, cleared once the consumer takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (trace_ready) begin
      valid_q <= 1'b0;
    end
  end

  // Record payload, captured at acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rvfi.rs1_addr         <= instr_rs1;
      rvfi.rs2_addr         <= instr_rs2;
      rvfi.rs1_rdata        <= rs1_rdata;
      rvfi.rs2_rdata        <= rs2_rdata;
      rvfi.dbg              <= dbg;
      rvfi.dbg_mode         <= dbg_mode;
      rvfi.trap             <= trap;
      rvfi.intr             <= intr;
      rvfi.csr_dcsr_rdata   <= dcsr_rdata;
      rvfi.csr_mcause_wdata <= mcause_wdata;
      rvfi.csr_mcause_wmask <= mcause_wmask;
    end
  end

  assign rvfi.valid = valid_q;

  // Stalled record holds until taken
  a_record_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_q && !trace_ready |=> valid_q &&
      $stable({rvfi.rs1_rdata, rvfi.rs2_rdata, rvfi.trap, rvfi.intr,
               rvfi.dbg_mode, rvfi.csr_mcause_wdata, rvfi.csr_dcsr_rdata})
  ) else $fatal(1, "ERR %0t retire_unit: record changed under stall", $time);

endmodule

// File: source/rvfi_checker.sv
// ================================================
// RVFI checker
// Passive assertions on the retirement records
// ================================================

`include "core_consts.svh"

module rvfi_checker (
  input logic     clk_i,
  input logic     rst_ni,
  rvfi_if.monitor rvfi
);

  default clocking cb @(posedge clk_i);
  endclocking

  default disable iff (!rst_ni);

  // Debug mode of the previous record
  logic                   was_dbg_mode;
  // One flag per register, set on its first read
  logic [`CORE_NREGS-1:0] reg_seen;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      was_dbg_mode <= 1'b0;
      reg_seen     <= '0;
    end else if (rvfi.valid) begin
      was_dbg_mode           <= rvfi.dbg_mode;
      reg_seen[rvfi.rs1_addr] <= 1'b1;
      reg_seen[rvfi.rs2_addr] <= 1'b1;
    end
  end

  // First read after reset sees the reset value
  a_rs1_reset_value: assert property (
    rvfi.valid && !reg_seen[rvfi.rs1_addr] |-> (rvfi.rs1_rdata == '0)
  ) else $fatal(1, "ERR %0t rvfi_checker: rs1 reset value not zero", $time);

  a_rs2_reset_value: assert property (
    rvfi.valid && !reg_seen[rvfi.rs2_addr] |-> (rvfi.rs2_rdata == '0)
  ) else $fatal(1, "ERR %0t rvfi_checker: rs2 reset value not zero", $time);

  // Debug entry cause agrees with dcsr
  a_dbg_cause: assert property (
    rvfi.valid && (rvfi.dbg != 3'd0) && !was_dbg_mode
    |-> (rvfi.dbg == rvfi.csr_dcsr_rdata[8:6])
  ) else $fatal(1, "ERR %0t rvfi_checker: dbg differs from dcsr.cause", $time);

  // Exception code agrees with the masked mcause write
  a_exc_cause: assert property (
    rvfi.valid && rvfi.trap.exception && !rvfi.dbg_mode
    |-> (`CORE_XLEN'(rvfi.trap.exception_cause)
         == (rvfi.csr_mcause_wdata & rvfi.csr_mcause_wmask))
  ) else $fatal(1, "ERR %0t rvfi_checker: exception cause differs from mcause", $time);

  // Every trap kind carries a cause
  a_exc_has_cause: assert property (
    rvfi.valid && rvfi.trap.exception |-> (rvfi.trap.exception_cause != 6'd0)
  ) else $fatal(1, "ERR %0t rvfi_checker: exception without cause", $time);

  a_irq_has_cause: assert property (
    rvfi.valid && rvfi.intr.interrupt |-> (rvfi.intr.cause != 11'd0)
  ) else $fatal(1, "ERR %0t rvfi_checker: interrupt without cause", $time);

  a_dbg_has_cause: assert property (
    rvfi.valid && rvfi.trap.debug |-> (rvfi.trap.debug_cause != 3'd0)
  ) else $fatal(1, "ERR %0t rvfi_checker: debug entry without cause", $time);

endmodule

// File: source/trace_core_top.sv
// ================================================
// Retirement-trace core, top level
// Issue port in, RVFI records out on plain ports
// ================================================

`include "core_consts.svh"

module trace_core_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  instr_valid,
  output logic                  instr_ready,
  input  core_pkg::opcode_e     instr_op,
  input  logic [4:0]            instr_rs1,
  input  logic [4:0]            instr_rs2,
  input  logic [4:0]            instr_rd,
  input  logic [`CORE_XLEN-1:0] instr_imm,
  input  logic                  irq,
  input  logic                  dbg_req,
  input  logic                  trace_ready,
  output logic                  rvfi_valid,
  output logic [4:0]            rvfi_rs1_addr,
  output logic [4:0]            rvfi_rs2_addr,
  output logic [`CORE_XLEN-1:0] rvfi_rs1_rdata,
  output logic [`CORE_XLEN-1:0] rvfi_rs2_rdata,
  output logic [2:0]            rvfi_dbg,
  output logic                  rvfi_dbg_mode,
  output rvfi_pkg::rvfi_trap_t  rvfi_trap,
  output rvfi_pkg::rvfi_intr_t  rvfi_intr,
  output logic [`CORE_XLEN-1:0] rvfi_csr_dcsr_rdata,
  output logic [`CORE_XLEN-1:0] rvfi_csr_mcause_wdata,
  output logic [`CORE_XLEN-1:0] rvfi_csr_mcause_wmask
);

  // Register file port
  logic [4:0]            rs1_addr;
  logic [4:0]            rs2_addr;
  logic [`CORE_XLEN-1:0] rs1_rdata;
  logic [`CORE_XLEN-1:0] rs2_rdata;
  logic                  we;
  logic [4:0]            waddr;
  logic [`CORE_XLEN-1:0] wdata;

  // Controller results
  logic                  accept;
  rvfi_pkg::rvfi_trap_t  trap;
  rvfi_pkg::rvfi_intr_t  intr;
  logic [2:0]            dbg;
  logic                  dbg_mode;
  logic                  suppress_wb;
  logic [`CORE_XLEN-1:0] dcsr_rdata;
  logic [`CORE_XLEN-1:0] mcause_wdata;
  logic [`CORE_XLEN-1:0] mcause_wmask;

  rvfi_if rvfi_bus ();

  reg_file i_reg_file (
    .clk_i, .rst_ni, .rs1_addr, .rs2_addr, .rs1_rdata, .rs2_rdata, .we, .waddr, .wdata
  );

  trap_ctrl i_trap_ctrl (
    .clk_i, .rst_ni, .accept, .op(instr_op), .irq, .dbg_req, .trap, .intr, .dbg,
    .dbg_mode, .suppress_wb, .dcsr_rdata, .mcause_wdata, .mcause_wmask
  );

  retire_unit i_retire_unit (
    .clk_i, .rst_ni, .instr_valid, .instr_ready, .instr_op, .instr_rs1, .instr_rs2,
    .instr_rd, .instr_imm, .trace_ready, .rvfi(rvfi_bus), .rs1_addr, .rs2_addr,
    .rs1_rdata, .rs2_rdata, .we, .waddr, .wdata, .accept, .trap, .intr, .dbg,
    .dbg_mode, .suppress_wb, .dcsr_rdata, .mcause_wdata, .mcause_wmask
  );

  rvfi_checker i_rvfi_checker (
    .clk_i, .rst_ni, .rvfi(rvfi_bus)
  );

  // Record flattened onto the trace port
  assign rvfi_valid            = rvfi_bus.valid;
  assign rvfi_rs1_addr         = rvfi_bus.rs1_addr;
  assign rvfi_rs2_addr         = rvfi_bus.rs2_addr;
  assign rvfi_rs1_rdata        = rvfi_bus.rs1_rdata;
  assign rvfi_rs2_rdata        = rvfi_bus.rs2_rdata;
  assign rvfi_dbg              = rvfi_bus.dbg;
  assign rvfi_dbg_mode         = rvfi_bus.dbg_mode;
  assign rvfi_trap             = rvfi_bus.trap;
  assign rvfi_intr             = rvfi_bus.intr;
  assign rvfi_csr_dcsr_rdata   = rvfi_bus.csr_dcsr_rdata;
  assign rvfi_csr_mcause_wdata = rvfi_bus.csr_mcause_wdata;
  assign rvfi_csr_mcause_wmask = rvfi_bus.csr_mcause_wmask;

endmodule

// File: sim/tb_clock_gen.sv
// ==================================================
// Testbench clock and reset
// Free-running clock, reset held low at start
// ==================================================

module tb_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_i,
  output logic rst_ni
);

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  // Release a quarter period after a rising edge, clear of both edges
  initial begin
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #(PERIOD / 4) rst_ni = 1'b1;
  end

endmodule

// File: sim/tb_trace_core.sv
// ==================================================
// Trace core testbench
// LFSR stimulus on the issue port, a register and
// CSR model, assertions on every retirement record
// ==================================================

`include "core_consts.svh"

module tb_trace_core;

  localparam int NUM_INSTR      = 400;
  localparam int NUM_SWEEP      = `CORE_NREGS / 2;
  localparam int MAX_STALL      = 8;
  localparam int RESET_CYCLES   = 16;
  // About 4000 cycles from the worst stall per instruction plus margin
  localparam int TIMEOUT_CYCLES = NUM_INSTR * (MAX_STALL + 2) + RESET_CYCLES;
  localparam int DRIVE_DELAY    = 10;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  instr_valid;
  logic                  instr_ready;
  core_pkg::opcode_e     instr_op;
  logic [4:0]            instr_rs1;
  logic [4:0]            instr_rs2;
  logic [4:0]            instr_rd;
  logic [`CORE_XLEN-1:0] instr_imm;
  logic                  irq;
  logic                  dbg_req;
  logic                  trace_ready;
  logic                  rvfi_valid;
  logic [4:0]            rvfi_rs1_addr;
  logic [4:0]            rvfi_rs2_addr;
  logic [`CORE_XLEN-1:0] rvfi_rs1_rdata;
  logic [`CORE_XLEN-1:0] rvfi_rs2_rdata;
  logic [2:0]            rvfi_dbg;
  logic                  rvfi_dbg_mode;
  rvfi_pkg::rvfi_trap_t  rvfi_trap;
  rvfi_pkg::rvfi_intr_t  rvfi_intr;
  logic [`CORE_XLEN-1:0] rvfi_csr_dcsr_rdata;
  logic [`CORE_XLEN-1:0] rvfi_csr_mcause_wdata;
  logic [`CORE_XLEN-1:0] rvfi_csr_mcause_wmask;

  // Reference model state
  logic [`CORE_XLEN-1:0] m_regs [`CORE_NREGS];
  logic                  m_dbg_mode;
  logic                  m_valid;
  logic                  m_took;
  logic [`CORE_XLEN-1:0] m_dcsr;
  logic [`CORE_XLEN-1:0] m_mcause;
  logic                  model_ready;
  logic                  model_accept;
  int                    n_accepted;
  // One flag per behavior hit by the stimulus
  // Bits 0 to 7 are exc in run, exc in debug, irq, irq in debug, ebreak, haltreq, dret and stall
  logic [7:0]            reached;

  // Expected record of the last accepted instruction
  logic [4:0]            exp_rs1_addr;
  logic [4:0]            exp_rs2_addr;
  logic [`CORE_XLEN-1:0] exp_rs1_rdata;
  logic [`CORE_XLEN-1:0] exp_rs2_rdata;
  logic [2:0]            exp_dbg;
  logic                  exp_dbg_mode;
  rvfi_pkg::rvfi_trap_t  exp_trap;
  rvfi_pkg::rvfi_intr_t  exp_intr;
  logic [`CORE_XLEN-1:0] exp_dcsr;
  logic [`CORE_XLEN-1:0] exp_mcause_wdata;
  logic [`CORE_XLEN-1:0] exp_mcause_wmask;

  logic [31:0]           lfsr_state;

  tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(RESET_CYCLES)) i_clock_gen (
    .clk_i, .rst_ni
  );

  trace_core_top i_dut (
    .clk_i, .rst_ni, .instr_valid, .instr_ready, .instr_op, .instr_rs1, .instr_rs2,
    .instr_rd, .instr_imm, .irq, .dbg_req, .trace_ready, .rvfi_valid, .rvfi_rs1_addr,
    .rvfi_rs2_addr, .rvfi_rs1_rdata, .rvfi_rs2_rdata, .rvfi_dbg, .rvfi_dbg_mode,
    .rvfi_trap, .rvfi_intr, .rvfi_csr_dcsr_rdata, .rvfi_csr_mcause_wdata,
    .rvfi_csr_mcause_wmask
  );

  // Taps 32, 22, 2, 1 give a maximal length sequence
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic report_error(input string msg);
    $display("ERR %0t %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // At most one record in flight and a stall only while it waits
  assign model_ready  = !(m_valid && !trace_ready);
  assign model_accept = instr_valid && model_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin : model_update
    logic                  in_run;
    logic [2:0]            cause;
    logic                  exc;
    logic [5:0]            code;
    logic                  irq_taken;
    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    logic [`CORE_XLEN-1:0] mask;
    logic [`CORE_XLEN-1:0] wdata;
    logic [`CORE_XLEN-1:0] dcsr;
    if (!rst_ni) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        m_regs[i] <= '0;
      end
      m_dbg_mode <= 1'b0;
      m_valid    <= 1'b0;
      m_took     <= 1'b0;
      m_dcsr     <= '0;
      m_mcause   <= '0;
      n_accepted <= 0;
      reached    <= '0;
    end else begin
      m_took <= model_accept;
      if (model_accept) begin
        in_run = !m_dbg_mode;
        // Halt request wins over ebreak and both need run mode
        cause = 3'd0;
        if (in_run && dbg_req) begin
          cause = 3'd3;
        end else if (in_run && (instr_op == core_pkg::OP_EBREAK)) begin
          cause = 3'd1;
        end
        exc = (cause == 3'd0) &&
              ((instr_op == core_pkg::OP_ECALL) || (instr_op == core_pkg::OP_ILLEGAL));
        code = (instr_op == core_pkg::OP_ECALL) ? 6'(`CORE_CAUSE_ECALL)
                                                 : 6'(`CORE_CAUSE_ILLEGAL);
        irq_taken = in_run && irq && (cause == 3'd0) && !exc;
        // Full mask replaces mcause and an empty mask keeps it
        mask  = '0;
        wdata = m_mcause;
        if (exc && in_run) begin
          mask  = '1;
          wdata = `CORE_XLEN'(code);
        end else if (irq_taken) begin
          mask  = '1;
          wdata = (`CORE_XLEN'(1) << `CORE_IRQ_BIT) | `CORE_XLEN'(`CORE_CAUSE_MEXT_IRQ);
        end
        dcsr = m_dcsr;
        if (cause != 3'd0) begin
          dcsr[8:6] = cause;
        end
        a = m_regs[instr_rs1];
        b = m_regs[instr_rs2];

        exp_rs1_addr     <= instr_rs1;
        exp_rs2_addr     <= instr_rs2;
        exp_rs1_rdata    <= a;
        exp_rs2_rdata    <= b;
        exp_dbg          <= cause;
        exp_dbg_mode     <= m_dbg_mode;
        exp_trap         <= '{exception: exc, exception_cause: exc ? code : 6'd0,
                              debug: (cause != 3'd0), debug_cause: cause};
        exp_intr         <= '{interrupt: irq_taken,
                              cause: irq_taken ? 11'(`CORE_CAUSE_MEXT_IRQ) : 11'd0};
        exp_dcsr         <= dcsr;
        exp_mcause_wdata <= wdata;
        exp_mcause_wmask <= mask;

        m_mcause   <= wdata;
        m_dcsr     <= dcsr;
        m_valid    <= 1'b1;
        n_accepted <= n_accepted + 1;
        if (cause != 3'd0) begin
          m_dbg_mode <= 1'b1;
        end else if (!in_run && (instr_op == core_pkg::OP_DRET)) begin
          m_dbg_mode <= 1'b0;
          reached[6] <= 1'b1;
        end
        // Trapped instructions and x0 keep their old value
        if (((instr_op == core_pkg::OP_ADD) || (instr_op == core_pkg::OP_ADDI)) &&
            (cause == 3'd0) && (instr_rd != 5'd0)) begin
          m_regs[instr_rd] <= a + ((instr_op == core_pkg::OP_ADD) ? b : instr_imm);
        end
        if (exc && in_run) reached[0] <= 1'b1;
        if (exc && !in_run) reached[1] <= 1'b1;
        if (irq_taken) reached[2] <= 1'b1;
        if (irq && !in_run) reached[3] <= 1'b1;
        if (cause == 3'd1) reached[4] <= 1'b1;
        if (cause == 3'd3) reached[5] <= 1'b1;
      end else if (trace_ready) begin
        m_valid <= 1'b0;
      end else if (m_valid) begin
        reached[7] <= 1'b1;
      end
    end
  end

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_ready == model_ready
  ) else report_error("instr_ready differs from the model");

  a_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid == m_valid
  ) else report_error("rvfi_valid differs from the model");

  // Record exactly one cycle after acceptance
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    model_accept |=> rvfi_valid
  ) else report_error("record missing one cycle after acceptance");

  a_sources: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid |-> (rvfi_rs1_addr == exp_rs1_addr) && (rvfi_rs2_addr == exp_rs2_addr) &&
                   (rvfi_rs1_rdata == exp_rs1_rdata) && (rvfi_rs2_rdata == exp_rs2_rdata)
  ) else report_error("source register address or data mismatch");

  a_trap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid |-> (rvfi_trap == exp_trap) && (rvfi_dbg == exp_dbg)
  ) else report_error("trap or debug cause mismatch");

  a_intr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid |-> (rvfi_intr == exp_intr)
  ) else report_error("interrupt field mismatch");

  a_dbg_mode: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid |-> (rvfi_dbg_mode == exp_dbg_mode)
  ) else report_error("dbg_mode mismatch");

  a_csr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid |-> (rvfi_csr_dcsr_rdata == exp_dcsr) &&
                   (rvfi_csr_mcause_wdata == exp_mcause_wdata) &&
                   (rvfi_csr_mcause_wmask == exp_mcause_wmask)
  ) else report_error("dcsr or mcause write mismatch");

  // Stalled record must not move
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid && !trace_ready |=> rvfi_valid &&
      $stable({rvfi_rs1_addr, rvfi_rs2_addr, rvfi_rs1_rdata, rvfi_rs2_rdata, rvfi_dbg,
               rvfi_dbg_mode, rvfi_trap, rvfi_intr, rvfi_csr_dcsr_rdata,
               rvfi_csr_mcause_wdata, rvfi_csr_mcause_wmask})
  ) else report_error("record changed while trace_ready was low");

  task automatic offer_instruction(input int sweep);
    logic [31:0] imm;
    if (sweep < NUM_SWEEP) begin
      // Read every register in pairs before anything is written
      instr_op  = core_pkg::OP_ADD;
      instr_rs1 = 5'(2 * sweep);
      instr_rs2 = 5'(2 * sweep + 1);
      instr_rd  = 5'd0;
      instr_imm = '0;
      irq       = 1'b0;
      dbg_req   = 1'b0;
    end else begin
      case (rand_bits(3))
        0, 1:    instr_op = core_pkg::OP_ADD;
        2, 3:    instr_op = core_pkg::OP_ADDI;
        4:       instr_op = core_pkg::OP_ECALL;
        5:       instr_op = core_pkg::OP_ILLEGAL;
        6:       instr_op = core_pkg::OP_EBREAK;
        default: instr_op = core_pkg::OP_DRET;
      endcase
      instr_rs1 = 5'(rand_bits(5));
      instr_rs2 = 5'(rand_bits(5));
      instr_rd  = 5'(rand_bits(5));
      imm       = rand_bits(12);
      instr_imm = {{20{imm[11]}}, imm[11:0]};
      irq       = (rand_bits(3) == 0);
      dbg_req   = (rand_bits(4) == 0);
    end
  endtask

  initial begin : stimulus
    int sweep;
    lfsr_state  = 32'h39ca2848;
    instr_valid = 1'b0;
    instr_op    = core_pkg::OP_ADD;
    instr_rs1   = 5'd0;
    instr_rs2   = 5'd0;
    instr_rd    = 5'd0;
    instr_imm   = '0;
    irq         = 1'b0;
    dbg_req     = 1'b0;
    trace_ready = 1'b1;
    sweep       = 0;
    @(posedge rst_ni);
    while (n_accepted < NUM_INSTR) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      trace_ready = (rand_bits(2) != 0);
      // Hold an offered instruction until it is taken
      if (m_took || !instr_valid) begin
        instr_valid = (n_accepted < NUM_INSTR) && (rand_bits(2) != 0);
        if (instr_valid) begin
          offer_instruction(sweep);
          sweep++;
        end
      end
    end
    instr_valid = 1'b0;
    trace_ready = 1'b1;
    repeat (3) @(posedge clk_i);
    if (&reached) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("Stimulus missed some behaviors, reached flags %b", reached);
      $display("TESTBENCH FAILED");
      $fatal(1, "incomplete stimulus");
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, only %0d of %0d instructions accepted",
             cycles, n_accepted, NUM_INSTR);
    $display("TESTBENCH FAILED");
    $fatal(1, "run did not finish");
  end

endmodule

// File: flist.f
+incdir+source
source/core_pkg.sv
source/rvfi_pkg.sv
source/rvfi_if.sv
source/reg_file.sv
source/trap_ctrl.sv
source/retire_unit.sv
source/rvfi_checker.sv
source/trace_core_top.sv
sim/tb_clock_gen.sv
sim/tb_trace_core.sv

// File: Makefile
TOP := tb_trace_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
